//--- hw/uart_pkg.sv
// UART package.
// Frame constants, the run-time configuration and the payloads shared by the
// transmit and receive paths.
`default_nettype none

package uart_pkg;

    // 8N1/8N2 framing only, so the data width is fixed.
    localparam int uart_data_width = 8;
    localparam int uart_div_width  = 16;

    // frame length in bit periods, start bit included.
    localparam int uart_frame_1stop     = 10;
    localparam int uart_frame_2stop     = 11;
    localparam int uart_frame_cnt_width = 4;

    // baud_div is in clock cycles per bit and must be at least 4.
    typedef struct packed {
        logic [uart_div_width-1:0] baud_div;
        logic                      two_stop;
    } uart_cfg_t;

    typedef struct packed {
        logic [uart_data_width-1:0] data;
    } uart_tx_req_t;

    // frame_err is set when the first stop bit was sampled low.
    typedef struct packed {
        logic [uart_data_width-1:0] data;
        logic                       frame_err;
    } uart_rx_byte_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } uart_tx_state_e;

endpackage : uart_pkg

`default_nettype wire

//--- hw/uart_fifo.sv
// Synchronous FIFO with a first-word-fall-through head and a type-parameter
// payload. Pushes when full and pops when empty are ignored.
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    parameter int  fifo_depth = 8,
    parameter type payload_t  = logic [7:0]
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           push_i,
    input  wire payload_t data_i,
    input  wire           pop_i,
    output payload_t      data_o,
    output logic          not_empty_o,
    output logic          full_o
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    payload_t         mem_q [fifo_depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // pointers wrap explicitly, so the depth need not be a power of two.
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o      = (count_q == cnt_w'(fifo_depth));
    assign not_empty_o = (count_q != '0);
    assign do_push     = push_i && !full_o;
    assign do_pop      = pop_i && not_empty_o;
    assign data_o      = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // a simultaneous push and pop leaves the occupancy as it is.
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule : uart_fifo

`default_nettype wire

//--- hw/uart_tx_arbiter.sv
// Round-robin arbiter between the two transmit queues.
// The grant is combinational; only the one-bit priority pointer is registered.
`timescale 1ns/1ps
`default_nettype none

module uart_tx_arbiter (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     req0_valid_i,
    input  wire uart_pkg::uart_tx_req_t req0_i,
    input  wire                     req1_valid_i,
    input  wire uart_pkg::uart_tx_req_t req1_i,
    output logic                    pop0_o,
    output logic                    pop1_o,
    input  wire                     tx_ready_i,
    output logic                    tx_valid_o,
    output uart_pkg::uart_tx_req_t  tx_req_o
);

    // prio_q low favours queue 0, high favours queue 1.
    logic prio_q;
    logic grant1;
    logic accept;

    // queue 1 wins when it is the only requester or when it holds priority.
    assign grant1 = req1_valid_i && (!req0_valid_i || prio_q);

    assign tx_valid_o = req0_valid_i || req1_valid_i;
    assign tx_req_o   = grant1 ? req1_i : req0_i;
    assign accept     = tx_valid_o && tx_ready_i;

    // the head leaves its queue on the same edge the transmitter takes it.
    assign pop0_o = accept && !grant1;
    assign pop1_o = accept && grant1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_q <= 1'b0;
        end else if (accept) begin
            // the queue that was just served drops to the lower priority.
            prio_q <= !grant1;
        end
    end

endmodule : uart_tx_arbiter

`default_nettype wire

//--- hw/uart_tx.sv
// UART transmitter.
// Frames one byte as a start bit, 8 data bits LSB first and one or two stop
// bits, each bit lasting baud_div clock cycles.
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire uart_pkg::uart_cfg_t cfg_i,
    input  wire                     valid_i,
    input  wire uart_pkg::uart_tx_req_t req_i,
    output logic                    ready_o,
    output logic                    tx_o
);

    import uart_pkg::*;

    localparam int shift_w = uart_data_width + 1;

    uart_tx_state_e                  state_q;
    uart_tx_state_e                  state_d;
    logic [uart_div_width-1:0]       baud_cnt_q;
    logic [uart_div_width-1:0]       baud_cnt_d;
    logic [uart_frame_cnt_width-1:0] bit_cnt_q;
    logic [uart_frame_cnt_width-1:0] bit_cnt_d;
    logic [uart_frame_cnt_width-1:0] frame_len;
    logic [uart_frame_cnt_width-1:0] stop_bits;
    logic [shift_w-1:0]              shift_q;
    logic [shift_w-1:0]              shift_d;
    logic [uart_div_width-1:0]       baud_q;
    logic                            two_stop_q;
    logic                            bit_end;
    logic                            accept;

    assign ready_o = (state_q == tx_idle);
    assign accept  = valid_i && ready_o;
    assign bit_end = (baud_cnt_q == '0);

    // the line idles high; otherwise the low end of the shifter is on the wire.
    assign tx_o = (state_q == tx_idle) ? 1'b1 : shift_q[0];

    assign frame_len = cfg_i.two_stop ? uart_frame_cnt_width'(uart_frame_2stop)
                                      : uart_frame_cnt_width'(uart_frame_1stop);
    assign stop_bits = two_stop_q ? uart_frame_cnt_width'(2) : uart_frame_cnt_width'(1);

    always_comb begin
        state_d    = state_q;
        baud_cnt_d = baud_cnt_q;
        bit_cnt_d  = bit_cnt_q;
        shift_d    = shift_q;

        // bit timing is common to every busy state.
        // ones are shifted in behind the data, which produces the stop bits.
        if (state_q != tx_idle) begin
            if (bit_end) begin
                baud_cnt_d = baud_q - 1'b1;
                bit_cnt_d  = bit_cnt_q - 1'b1;
                shift_d    = {1'b1, shift_q[shift_w-1:1]};
            end else begin
                baud_cnt_d = baud_cnt_q - 1'b1;
            end
        end

        case (state_q)
            tx_idle: begin
                if (valid_i) begin
                    shift_d    = {req_i.data, 1'b0};
                    baud_cnt_d = cfg_i.baud_div - 1'b1;
                    bit_cnt_d  = frame_len - 1'b1;
                    state_d    = tx_start;
                end
            end
            tx_start: begin
                if (bit_end) begin
                    state_d = tx_data;
                end
            end
            tx_data: begin
                // bit_cnt_q counts the bits still to come after this one.
                if (bit_end && (bit_cnt_q == stop_bits)) begin
                    state_d = tx_stop;
                end
            end
            tx_stop: begin
                if (bit_end && (bit_cnt_q == '0)) begin
                    state_d = tx_idle;
                end
            end
            default: begin
                state_d = tx_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= tx_idle;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else begin
            state_q    <= state_d;
            baud_cnt_q <= baud_cnt_d;
            bit_cnt_q  <= bit_cnt_d;
        end
    end

    // configuration is captured at acceptance and held for the whole frame.
    always_ff @(posedge clk) begin
        shift_q <= shift_d;
        if (accept) begin
            baud_q     <= cfg_i.baud_div;
            two_stop_q <= cfg_i.two_stop;
        end
    end

endmodule : uart_tx

`default_nettype wire

//--- hw/uart_rx.sv
// UART receiver.
// Synchronises the line, finds the start bit, samples 8 data bits and the first
// stop bit at mid-bit and reports each byte with a frame-error flag.
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire uart_pkg::uart_cfg_t cfg_i,
    input  wire                      rx_i,
    output logic                     valid_o,
    output uart_pkg::uart_rx_byte_t  byte_o
);

    import uart_pkg::*;

    localparam int idx_w = $clog2(uart_data_width);

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop,
        rx_tail
    } rx_state_e;

    rx_state_e                  state_q;
    rx_state_e                  state_d;
    logic [1:0]                 sync_q;
    logic                       rx_s;
    logic [uart_div_width-1:0]  cnt_q;
    logic [uart_div_width-1:0]  cnt_d;
    logic [uart_div_width-1:0]  baud_q;
    logic [idx_w-1:0]           bit_idx_q;
    logic [idx_w-1:0]           bit_idx_d;
    logic [uart_data_width-1:0] shift_q;
    logic [uart_data_width-1:0] shift_d;
    logic                       err_q;
    logic                       err_d;
    logic                       valid_d;
    logic                       tick;

    // two flops against metastability; rx_s is the synchronised line.
    assign rx_s = sync_q[1];
    assign tick = (cnt_q == '0);

    assign byte_o = '{data: shift_q, frame_err: err_q};

    always_comb begin
        state_d   = state_q;
        cnt_d     = tick ? cnt_q : cnt_q - 1'b1;
        bit_idx_d = bit_idx_q;
        shift_d   = shift_q;
        err_d     = err_q;
        valid_d   = 1'b0;

        case (state_q)
            rx_idle: begin
                // the line idles high, so a low level here is the start edge.
                if (!rx_s) begin
                    cnt_d   = (cfg_i.baud_div >> 1) - 1'b1;
                    state_d = rx_start;
                end
            end
            rx_start: begin
                if (tick) begin
                    if (rx_s) begin
                        // line is high again at mid start bit; a glitch.
                        state_d = rx_idle;
                    end else begin
                        cnt_d     = baud_q - 1'b1;
                        bit_idx_d = '0;
                        state_d   = rx_data;
                    end
                end
            end
            rx_data: begin
                if (tick) begin
                    shift_d   = {rx_s, shift_q[uart_data_width-1:1]};
                    cnt_d     = baud_q - 1'b1;
                    bit_idx_d = bit_idx_q + 1'b1;
                    if (bit_idx_q == idx_w'(uart_data_width - 1)) begin
                        state_d = rx_stop;
                    end
                end
            end
            rx_stop: begin
                // Only the first stop bit is checked.
                if (tick) begin
                    err_d   = !rx_s;
                    cnt_d   = (baud_q >> 1) - 1'b1;
                    state_d = rx_tail;
                end
            end
            rx_tail: begin
                if (tick) begin
                    valid_d = 1'b1;
                    state_d = rx_idle;
                end
            end
            default: begin
                state_d = rx_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q    <= 2'b11;
            state_q   <= rx_idle;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            valid_o   <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], rx_i};
            state_q   <= state_d;
            cnt_q     <= cnt_d;
            bit_idx_q <= bit_idx_d;
            valid_o   <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        shift_q <= shift_d;
        err_q   <= err_d;
        // the divisor is held from start detection to the end of the frame.
        if ((state_q == rx_idle) && !rx_s) begin
            baud_q <= cfg_i.baud_div;
        end
    end

endmodule : uart_rx

`default_nettype wire

//--- hw/uart_top.sv
// Two-client UART subsystem.
// Two transmit queues share one transmitter through a round-robin arbiter; the
// receiver fills a receive queue that the host pops.
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    parameter int tx_depth = 8,
    parameter int rx_depth = 8
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire uart_pkg::uart_cfg_t            cfg_i,
    input  wire                                 a_push_i,
    input  wire [uart_pkg::uart_data_width-1:0] a_data_i,
    output logic                                a_full_o,
    input  wire                                 b_push_i,
    input  wire [uart_pkg::uart_data_width-1:0] b_data_i,
    output logic                                b_full_o,
    output logic                                tx_o,
    input  wire                                 rx_i,
    input  wire                                 rx_pop_i,
    output logic                                rx_avail_o,
    output uart_pkg::uart_rx_byte_t             rx_byte_o,
    output logic                                rx_overrun_o
);

    import uart_pkg::*;

    uart_tx_req_t  a_req;
    uart_tx_req_t  b_req;
    uart_tx_req_t  a_head;
    uart_tx_req_t  b_head;
    uart_tx_req_t  tx_req;
    uart_rx_byte_t rx_byte;
    logic          a_not_empty;
    logic          b_not_empty;
    logic          a_pop;
    logic          b_pop;
    logic          tx_valid;
    logic          tx_ready;
    logic          rx_valid;
    logic          rx_full;

    assign a_req = '{data: a_data_i};
    assign b_req = '{data: b_data_i};

    uart_fifo #(.fifo_depth(tx_depth), .payload_t(uart_tx_req_t)) u_txq_a (
        .clk, .rst_n, .push_i(a_push_i), .data_i(a_req), .pop_i(a_pop),
        .data_o(a_head), .not_empty_o(a_not_empty), .full_o(a_full_o)
    );

    uart_fifo #(.fifo_depth(tx_depth), .payload_t(uart_tx_req_t)) u_txq_b (
        .clk, .rst_n, .push_i(b_push_i), .data_i(b_req), .pop_i(b_pop),
        .data_o(b_head), .not_empty_o(b_not_empty), .full_o(b_full_o)
    );

    uart_tx_arbiter u_arb (
        .clk, .rst_n,
        .req0_valid_i(a_not_empty), .req0_i(a_head),
        .req1_valid_i(b_not_empty), .req1_i(b_head),
        .pop0_o(a_pop), .pop1_o(b_pop),
        .tx_ready_i(tx_ready), .tx_valid_o(tx_valid), .tx_req_o(tx_req)
    );

    uart_tx u_tx (
        .clk, .rst_n, .cfg_i, .valid_i(tx_valid), .req_i(tx_req),
        .ready_o(tx_ready), .tx_o
    );

    uart_rx u_rx (
        .clk, .rst_n, .cfg_i, .rx_i, .valid_o(rx_valid), .byte_o(rx_byte)
    );

    uart_fifo #(.fifo_depth(rx_depth), .payload_t(uart_rx_byte_t)) u_rxq (
        .clk, .rst_n, .push_i(rx_valid), .data_i(rx_byte), .pop_i(rx_pop_i),
        .data_o(rx_byte_o), .not_empty_o(rx_avail_o), .full_o(rx_full)
    );

    // sticky until reset; the byte that hit a full queue is lost.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_overrun_o <= 1'b0;
        end else if (rx_valid && rx_full) begin
            rx_overrun_o <= 1'b1;
        end
    end

endmodule : uart_top

`default_nettype wire

//--- verif/uart_line_model.sv
// UART line model for the testbench.
// Decodes frames seen on the transmit line and drives queued frames onto the
// receive line, both at the bit period the testbench has configured.
`timescale 1ns/1ps
`default_nettype none

module uart_line_model (
    input  wire        clk,
    input  wire [15:0] baud_div_i,
    input  wire        tx_i,
    output logic       rx_o
);

    logic [7:0] tx_data_q[$];
    int         tx_stops_q[$];
    logic [8:0] rx_frame_q[$];

    function automatic int frames_decoded();
        return tx_data_q.size();
    endfunction

    task automatic take_frame(output logic [7:0] data, output int stops);
        data  = tx_data_q.pop_front();
        stops = tx_stops_q.pop_front();
    endtask

    // bit 8 of a queued frame makes its stop bit low.
    task automatic queue_frame(input logic [7:0] data, input logic bad_stop);
        rx_frame_q.push_back({bad_stop, data});
    endtask

    task automatic send_bit(input logic value);
        rx_o = value;
        repeat (baud_div_i) @(posedge clk);
        #1;
    endtask

    // the transmit line is sampled on the falling edge, clear of DUT updates.
    initial begin : decode
        logic [7:0] data;
        int         stops;
        bit         start_seen;
        start_seen = 1'b0;
        forever begin
            if (!start_seen) begin
                do begin
                    @(negedge clk);
                end while (tx_i !== 1'b0);
            end
            start_seen = 1'b0;
            repeat (baud_div_i / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (baud_div_i) @(negedge clk);
                data[i] = tx_i;
            end
            repeat (baud_div_i) @(negedge clk);
            stops = (tx_i === 1'b1) ? 1 : 0;
            // count up to two more whole high periods before the next start bit.
            for (int p = 0; p < 2 && stops > 0 && !start_seen; p++) begin
                for (int c = 0; c < baud_div_i && !start_seen; c++) begin
                    @(negedge clk);
                    start_seen = (tx_i === 1'b0);
                end
                if (!start_seen) begin
                    stops++;
                end
            end
            tx_data_q.push_back(data);
            tx_stops_q.push_back(stops);
        end
    end

    initial begin : drive
        logic [8:0] frame;
        rx_o = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (rx_frame_q.size() > 0) begin
                frame = rx_frame_q.pop_front();
                send_bit(1'b0);
                for (int i = 0; i < 8; i++) begin
                    send_bit(frame[i]);
                end
                send_bit(!frame[8]);
                // one idle period lets the receiver finish after a bad stop bit.
                send_bit(1'b1);
            end
        end
    end

endmodule : uart_line_model

`default_nettype wire

//--- verif/uart_tb.sv
// Testbench for the two-client UART subsystem.
// Random traffic on both transmit ports and on the receive line, checked
// against a model of the queues, the round-robin order and the overrun flag.
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    import uart_pkg::*;

    localparam int tx_depth    = 4;
    localparam int rx_depth    = 4;
    localparam int frame_limit = 500;

    logic          clk;
    logic          rst_n;
    uart_cfg_t     cfg;
    logic          a_push;
    logic [7:0]    a_data;
    logic          a_full;
    logic          b_push;
    logic [7:0]    b_data;
    logic          b_full;
    logic          tx;
    logic          rx;
    logic          rx_pop;
    logic          rx_avail;
    uart_rx_byte_t rx_byte;
    logic          rx_overrun;

    // model of the client queues, the arbiter pointer and the expected order.
    logic [7:0]    a_q[$];
    logic [7:0]    b_q[$];
    logic [7:0]    order_q[$];
    logic [8:0]    rx_exp_q[$];
    logic          prio;
    int            seed;

    uart_top #(.tx_depth(tx_depth), .rx_depth(rx_depth)) UUT (
        .clk, .rst_n, .cfg_i(cfg),
        .a_push_i(a_push), .a_data_i(a_data), .a_full_o(a_full),
        .b_push_i(b_push), .b_data_i(b_data), .b_full_o(b_full),
        .tx_o(tx), .rx_i(rx), .rx_pop_i(rx_pop), .rx_avail_o(rx_avail),
        .rx_byte_o(rx_byte), .rx_overrun_o(rx_overrun)
    );

    uart_line_model model (.clk, .baud_div_i(cfg.baud_div), .tx_i(tx), .rx_o(rx));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "stopping after a mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("Result: FAILED");
        $fatal(1, "stopping after a timeout");
    endtask

    // pushes start together on an idle transmitter, which takes the first byte
    // at once, so tx_depth more fit behind it and later pushes are dropped.
    task automatic push_burst(input int na, input int nb);
        for (int k = 0; k < na || k < nb; k++) begin
            @(posedge clk);
            #1;
            a_push = (k < na);
            b_push = (k < nb);
            a_data = $urandom;
            b_data = $urandom;
            if (k < na) begin
                check("a_full", k > tx_depth, a_full);
                if (k <= tx_depth) begin
                    a_q.push_back(a_data);
                end
            end
            if (k < nb) begin
                check("b_full", k > tx_depth, b_full);
                if (k <= tx_depth) begin
                    b_q.push_back(b_data);
                end
            end
        end
        @(posedge clk);
        #1;
        a_push = 1'b0;
        b_push = 1'b0;
    endtask

    // after a grant to one client the other one has priority.
    task automatic build_order();
        while (a_q.size() > 0 || b_q.size() > 0) begin
            if (b_q.size() > 0 && (a_q.size() == 0 || prio)) begin
                order_q.push_back(b_q.pop_front());
                prio = 1'b0;
            end else begin
                order_q.push_back(a_q.pop_front());
                prio = 1'b1;
            end
        end
    endtask

    task automatic expect_frames();
        logic [7:0] d;
        int         stops;
        int         n;
        int         cycles;
        n = order_q.size();
        for (int j = 0; j < n; j++) begin
            cycles = 0;
            while (model.frames_decoded() == 0) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles > frame_limit) begin
                    report_timeout("a frame on the transmit line");
                end
            end
            model.take_frame(d, stops);
            check("tx_data", order_q.pop_front(), d);
            // The last frame of a burst runs into an idle line and reads as three.
            check("tx_stops", (j == n - 1) ? 3 : (cfg.two_stop ? 2 : 1), stops);
        end
        check("tx_extra", 0, model.frames_decoded());
    endtask

    task automatic send_frames(input int n);
        logic [7:0] d;
        logic       bad;
        for (int i = 0; i < n; i++) begin
            d = $urandom;
            // a batch opens with one bad and one good stop bit.
            if (i < 2) begin
                bad = (i == 0);
            end else begin
                bad = ($urandom % 4) == 0;
            end
            model.queue_frame(d, bad);
            rx_exp_q.push_back({d, bad});
        end
    endtask

    task automatic drain_rx(input int n);
        int cycles;
        for (int i = 0; i < n; i++) begin
            cycles = 0;
            while (!rx_avail) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles > frame_limit) begin
                    report_timeout("a received byte");
                end
            end
            check("rx_byte", rx_exp_q.pop_front(), rx_byte);
            rx_pop = 1'b1;
            @(posedge clk);
            #1;
            rx_pop = 1'b0;
        end
        check("rx_avail_after_pop", 0, rx_avail);
    endtask

    initial begin
        int cycles;
        seed = 32'h38f3_6985;
        void'($urandom(seed));
        rst_n  = 1'b0;
        cfg    = '{baud_div: 16'd8, two_stop: 1'b0};
        a_push = 1'b0;
        a_data = '0;
        b_push = 1'b0;
        b_data = '0;
        rx_pop = 1'b0;
        prio   = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("tx_idle", 1, tx);
        check("rx_avail_reset", 0, rx_avail);
        check("rx_overrun_reset", 0, rx_overrun);
        check("a_full_reset", 0, a_full);
        check("b_full_reset", 0, b_full);

        // single frames from port A, then the same with two stop bits.
        cfg.baud_div = 16'(4 + $urandom % 9);
        push_burst(1 + $urandom % (tx_depth + 1), 0);
        build_order();
        expect_frames();
        cfg.baud_div = 16'(4 + $urandom % 9);
        cfg.two_stop = 1'b1;
        push_burst(2 + $urandom % tx_depth, 0);
        build_order();
        expect_frames();

        // both clients at once, then overfilling each port alone.
        cfg.baud_div = 16'(4 + $urandom % 9);
        cfg.two_stop = $urandom % 2;
        push_burst(1 + $urandom % tx_depth, 1 + $urandom % tx_depth);
        build_order();
        expect_frames();
        cfg.two_stop = 1'b0;
        push_burst(tx_depth + 2 + $urandom % 3, 0);
        build_order();
        expect_frames();
        push_burst(0, tx_depth + 2 + $urandom % 3);
        build_order();
        expect_frames();

        // reception with popping, then overrun without popping.
        cfg.baud_div = 16'(4 + $urandom % 9);
        send_frames(1 + $urandom % rx_depth);
        drain_rx(rx_exp_q.size());
        check("rx_overrun_clear", 0, rx_overrun);
        send_frames(rx_depth + 1);
        rx_exp_q.delete(rx_depth);
        cycles = 0;
        while (!rx_overrun) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > (rx_depth + 1) * frame_limit) begin
                report_timeout("the receive overrun flag to rise");
            end
        end
        drain_rx(rx_depth);
        check("rx_overrun_sticky", 1, rx_overrun);

        if (model.frames_decoded() != 0 || order_q.size() != 0) begin
            $display("frames on the transmit line do not match the model");
            $display("Result: FAILED");
            $fatal(1, "stopping after a frame count mismatch");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule : uart_tb

`default_nettype wire

//--- list.f
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_tx_arbiter.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
verif/uart_line_model.sv
verif/uart_tb.sv
